//--- Bender.yml
package:
  name: chacha_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - chacha_state_pkg.sv
      - chacha_ctrl_pkg.sv
      - chacha_qr.sv
      - chacha_init_state.sv
      - chacha_round.sv
      - chacha_block_ctr.sv
      - chacha_finalize.sv
      - chacha_ctrl.sv
      - chacha_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_chacha_core.sv

//--- chacha_block_ctr.sv
/*
 * 64-bit block counter as two 32-bit halves
 * Upper half steps only when the lower half wraps
 */
`timescale 1ns/1ps
`include "chacha_defines.svh"

module chacha_block_ctr (
  input  logic                     clk,
  input  logic                     dr_ctr_rst,
  input  logic                     ctr_set,
  input  logic                     ctr_inc,
  input  logic [`CHACHA_CTR_W-1:0] ctr,
  output logic [`CHACHA_CTR_W-1:0] block_ctr
);

  localparam int HALF_W = `CHACHA_CTR_W / 2;

  logic [HALF_W-1:0] lo_r;
  logic [HALF_W-1:0] hi_r;

  always_ff @(posedge clk)
  begin
    if (dr_ctr_rst)
    begin
      lo_r <= '0;
      hi_r <= '0;
    end
    else if (ctr_set)
    begin
      lo_r <= ctr[HALF_W-1:0];
      hi_r <= ctr[`CHACHA_CTR_W-1:HALF_W];
    end
    else if (ctr_inc)
    begin
      lo_r <= lo_r + 1'b1;
      // Carry decided from the low half value, adders stay separate
      if (lo_r == '1)
      begin
        hi_r <= hi_r + 1'b1;
      end
    end
  end

  assign block_ctr = {hi_r, lo_r};

  // Init and next never both accepted in one cycle
  a_set_xor_inc: assert property (@(posedge clk) disable iff (dr_ctr_rst)
    !(ctr_set && ctr_inc));

endmodule

//--- chacha_core.sv
/*
 * ChaCha block function core, 256-bit key, 64-bit nonce and counter
 * key, iv, rounds and data_in must hold from the pulse until valid
 * Result ready rounds+2 cycles after the accepting edge
 */
`timescale 1ns/1ps
`include "chacha_defines.svh"

module chacha_core (
  input  logic                        clk,
  input  logic                        dr_ctr_rst,
  input  logic                        init,
  input  logic                        next,
  input  logic [`CHACHA_KEY_W-1:0]    key,
  input  logic [`CHACHA_IV_W-1:0]     iv,
  input  logic [`CHACHA_CTR_W-1:0]    ctr,
  input  logic [`CHACHA_ROUNDS_W-1:0] rounds,
  input  logic [`CHACHA_BLOCK_W-1:0]  data_in,
  output logic                        ready,
  output logic [`CHACHA_BLOCK_W-1:0]  data_out,
  output logic                        data_out_valid
);

  logic                     ctr_set;
  logic                     ctr_inc;
  logic                     load_state;
  logic                     update_state;
  logic                     diag_sel;
  logic                     update_output;
  logic [`CHACHA_CTR_W-1:0] block_ctr;
  chacha_state_pkg::state_t init_words;
  chacha_state_pkg::state_t state_words;

  chacha_ctrl u_ctrl (
    .clk            (clk),
    .dr_ctr_rst     (dr_ctr_rst),
    .init           (init),
    .next           (next),
    .rounds         (rounds),
    .ctr_set        (ctr_set),
    .ctr_inc        (ctr_inc),
    .load_state     (load_state),
    .update_state   (update_state),
    .diag_sel       (diag_sel),
    .update_output  (update_output),
    .ready          (ready),
    .data_out_valid (data_out_valid)
  );

  chacha_block_ctr u_block_ctr (
    .clk        (clk),
    .dr_ctr_rst (dr_ctr_rst),
    .ctr_set    (ctr_set),
    .ctr_inc    (ctr_inc),
    .ctr        (ctr),
    .block_ctr  (block_ctr)
  );

  chacha_init_state u_init_state (
    .key        (key),
    .iv         (iv),
    .block_ctr  (block_ctr),
    .init_words (init_words)
  );

  chacha_round u_round (
    .clk          (clk),
    .dr_ctr_rst   (dr_ctr_rst),
    .load_state   (load_state),
    .update_state (update_state),
    .diag_sel     (diag_sel),
    .init_words   (init_words),
    .state_words  (state_words)
  );

  chacha_finalize u_finalize (
    .clk           (clk),
    .dr_ctr_rst    (dr_ctr_rst),
    .update_output (update_output),
    .init_words    (init_words),
    .state_words   (state_words),
    .data_in       (data_in),
    .data_out      (data_out)
  );

  // --------------------------------------------------
  // Mid-operation checks
  // --------------------------------------------------
  // Key, nonce and round count held while the block is computed
  a_operands_stable: assert property (@(posedge clk) disable iff (dr_ctr_rst)
    (u_ctrl.state_r inside {chacha_ctrl_pkg::INIT, chacha_ctrl_pkg::ROUNDS,
                            chacha_ctrl_pkg::FINALIZE})
      |-> ($stable(key) && $stable(iv) && $stable(rounds)));

  // data_in held up to the FINALIZE sample
  a_data_stable: assert property (@(posedge clk) disable iff (dr_ctr_rst)
    (u_ctrl.state_r inside {chacha_ctrl_pkg::INIT, chacha_ctrl_pkg::ROUNDS,
                            chacha_ctrl_pkg::FINALIZE})
      |-> $stable(data_in));

endmodule

//--- chacha_ctrl.sv
/*
 * Controller FSM, one quarterround step per cycle in ROUNDS
 * rounds must be even and nonzero when a pulse is accepted
 * Pulses arriving while busy are dropped
 */
`timescale 1ns/1ps
`include "chacha_defines.svh"

module chacha_ctrl (
  input  logic                        clk,
  input  logic                        dr_ctr_rst,
  input  logic                        init,
  input  logic                        next,
  input  logic [`CHACHA_ROUNDS_W-1:0] rounds,
  output logic                        ctr_set,
  output logic                        ctr_inc,
  output logic                        load_state,
  output logic                        update_state,
  output logic                        diag_sel,
  output logic                        update_output,
  output logic                        ready,
  output logic                        data_out_valid
);

  chacha_ctrl_pkg::ctrl_state_t state_r;
  chacha_ctrl_pkg::ctrl_state_t state_nxt;
  logic                         qr_ctr_r;
  logic [`CHACHA_DR_W-1:0]      dr_ctr_r;
  logic                         round_clr;
  logic                         dr_inc;

  // --------------------------------------------------
  // Next state and strobes
  // --------------------------------------------------
  always_comb
  begin
    state_nxt     = state_r;
    ctr_set       = 1'b0;
    ctr_inc       = 1'b0;
    load_state    = 1'b0;
    update_state  = 1'b0;
    update_output = 1'b0;
    round_clr     = 1'b0;
    dr_inc        = 1'b0;
    case (state_r)
      chacha_ctrl_pkg::IDLE,
      chacha_ctrl_pkg::DONE:
      begin
        // Init wins over next
        if (init)
        begin
          ctr_set   = 1'b1;
          state_nxt = chacha_ctrl_pkg::INIT;
        end
        else if (next)
        begin
          ctr_inc   = 1'b1;
          state_nxt = chacha_ctrl_pkg::INIT;
        end
      end
      chacha_ctrl_pkg::INIT:
      begin
        load_state = 1'b1;
        round_clr  = 1'b1;
        state_nxt  = chacha_ctrl_pkg::ROUNDS;
      end
      chacha_ctrl_pkg::ROUNDS:
      begin
        update_state = 1'b1;
        // Diagonal step closes a double round
        if (qr_ctr_r)
        begin
          dr_inc = 1'b1;
          if (dr_ctr_r == rounds[`CHACHA_ROUNDS_W-1:1] - 1'b1)
          begin
            state_nxt = chacha_ctrl_pkg::FINALIZE;
          end
        end
      end
      chacha_ctrl_pkg::FINALIZE:
      begin
        update_output = 1'b1;
        state_nxt     = chacha_ctrl_pkg::DONE;
      end
      default:
      begin
        state_nxt = chacha_ctrl_pkg::IDLE;
      end
    endcase
  end

  // --------------------------------------------------
  // State and round counters
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (dr_ctr_rst)
    begin
      state_r  <= chacha_ctrl_pkg::IDLE;
      qr_ctr_r <= 1'b0;
      dr_ctr_r <= '0;
    end
    else
    begin
      state_r <= state_nxt;
      if (round_clr)
      begin
        qr_ctr_r <= 1'b0;
        dr_ctr_r <= '0;
      end
      else
      begin
        if (update_state)
        begin
          qr_ctr_r <= ~qr_ctr_r;
        end
        if (dr_inc)
        begin
          dr_ctr_r <= dr_ctr_r + 1'b1;
        end
      end
    end
  end

  // 0 columns, 1 diagonals
  assign diag_sel       = qr_ctr_r;
  assign ready          = (state_r == chacha_ctrl_pkg::IDLE) || (state_r == chacha_ctrl_pkg::DONE);
  assign data_out_valid = (state_r == chacha_ctrl_pkg::DONE);

  // Round count seen at acceptance drives the whole operation
  a_rounds_legal: assert property (@(posedge clk) disable iff (dr_ctr_rst)
    (ready && (init || next)) |-> (!rounds[0] && rounds != '0));

endmodule

//--- chacha_ctrl_pkg.sv
/*
 * Controller state encoding for the ChaCha core
 */
package chacha_ctrl_pkg;

  // IDLE until first pulse, DONE holds the result
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    INIT     = 3'd1,
    ROUNDS   = 3'd2,
    FINALIZE = 3'd3,
    DONE     = 3'd4
  } ctrl_state_t;

endpackage

//--- chacha_defines.svh
/*
 * Widths and limits for the ChaCha core, 256-bit key mode only
 * The rounds port must carry an even count from 2 to 20
 */
`ifndef CHACHA_DEFINES_SVH
`define CHACHA_DEFINES_SVH

// State word and word count
`define CHACHA_WORD_W    32
`define CHACHA_NUM_WORDS 16

// Port widths
`define CHACHA_KEY_W    256
`define CHACHA_IV_W     64
`define CHACHA_CTR_W    64
`define CHACHA_BLOCK_W  512
`define CHACHA_ROUNDS_W 5

// Double-round counter, holds up to rounds/2
`define CHACHA_DR_W 4

`endif

//--- chacha_finalize.sv
/*
 * Feed-forward add, little endian output, XOR with data_in
 * data_in and the initial words are sampled on update_output
 */
`timescale 1ns/1ps
`include "chacha_defines.svh"

module chacha_finalize (
  input  logic                       clk,
  input  logic                       dr_ctr_rst,
  input  logic                       update_output,
  input  chacha_state_pkg::state_t   init_words,
  input  chacha_state_pkg::state_t   state_words,
  input  logic [`CHACHA_BLOCK_W-1:0] data_in,
  output logic [`CHACHA_BLOCK_W-1:0] data_out
);

  logic [`CHACHA_BLOCK_W-1:0] key_stream;

  // Word 0 lands in the top bits
  always_comb
  begin
    chacha_state_pkg::word_t sum;
    for (int i = 0; i < `CHACHA_NUM_WORDS; i++)
    begin
      sum = init_words[i] + state_words[i];
      key_stream[`CHACHA_BLOCK_W-1 - `CHACHA_WORD_W*i -: `CHACHA_WORD_W] =
        chacha_state_pkg::byte_swap(sum);
    end
  end

  // Output held until the next finalize
  always_ff @(posedge clk)
  begin
    if (dr_ctr_rst)
    begin
      data_out <= '0;
    end
    else if (update_output)
    begin
      data_out <= data_in ^ key_stream;
    end
  end

endmodule

//--- chacha_init_state.sv
/*
 * Builds the initial ChaCha state, combinational
 * Key and nonce arrive big endian, counter words are used as is
 */
`timescale 1ns/1ps
`include "chacha_defines.svh"

module chacha_init_state (
  input  logic [`CHACHA_KEY_W-1:0]  key,
  input  logic [`CHACHA_IV_W-1:0]   iv,
  input  logic [`CHACHA_CTR_W-1:0]  block_ctr,
  output chacha_state_pkg::state_t  init_words
);

  localparam int W = `CHACHA_WORD_W;

  always_comb
  begin
    // Constant row
    init_words[0] = chacha_state_pkg::SIGMA0;
    init_words[1] = chacha_state_pkg::SIGMA1;
    init_words[2] = chacha_state_pkg::SIGMA2;
    init_words[3] = chacha_state_pkg::SIGMA3;
    // Key words 4 to 11, most significant key word first
    for (int i = 0; i < `CHACHA_KEY_W / W; i++)
    begin
      init_words[4 + i] = chacha_state_pkg::byte_swap(key[`CHACHA_KEY_W-1 - W*i -: W]);
    end
    // Counter, low half first
    init_words[12] = block_ctr[W-1:0];
    init_words[13] = block_ctr[2*W-1:W];
    // Nonce
    init_words[14] = chacha_state_pkg::byte_swap(iv[2*W-1:W]);
    init_words[15] = chacha_state_pkg::byte_swap(iv[W-1:0]);
  end

endmodule

//--- chacha_qr.sv
/*
 * One ChaCha quarterround, purely combinational
 */
`timescale 1ns/1ps

module chacha_qr (
  input  chacha_state_pkg::word_t a,
  input  chacha_state_pkg::word_t b,
  input  chacha_state_pkg::word_t c,
  input  chacha_state_pkg::word_t d,
  output chacha_state_pkg::word_t a_prim,
  output chacha_state_pkg::word_t b_prim,
  output chacha_state_pkg::word_t c_prim,
  output chacha_state_pkg::word_t d_prim
);

  // Rotate left by a fixed amount
  function automatic chacha_state_pkg::word_t rotl(input chacha_state_pkg::word_t x,
                                                   input int n);
    return (x << n) | (x >> (32 - n));
  endfunction

  always_comb
  begin
    chacha_state_pkg::word_t a0;
    chacha_state_pkg::word_t b0;
    chacha_state_pkg::word_t c0;
    chacha_state_pkg::word_t d0;
    // First half, rotations 16 and 12
    a0 = a + b;
    d0 = rotl(d ^ a0, 16);
    c0 = c + d0;
    b0 = rotl(b ^ c0, 12);
    // Second half, rotations 8 and 7
    a_prim = a0 + b0;
    d_prim = rotl(d0 ^ a_prim, 8);
    c_prim = c0 + d_prim;
    b_prim = rotl(b0 ^ c_prim, 7);
  end

endmodule

//--- chacha_round.sv
/*
 * Working state register with four parallel quarterrounds
 * One column or diagonal step per update_state cycle
 */
`timescale 1ns/1ps
`include "chacha_defines.svh"

module chacha_round (
  input  logic                      clk,
  input  logic                      dr_ctr_rst,
  input  logic                      load_state,
  input  logic                      update_state,
  input  logic                      diag_sel,
  input  chacha_state_pkg::state_t  init_words,
  output chacha_state_pkg::state_t  state_words
);

  chacha_state_pkg::state_t state_r;
  chacha_state_pkg::state_t round_next;
  chacha_state_pkg::word_t  qa [4];
  chacha_state_pkg::word_t  qb [4];
  chacha_state_pkg::word_t  qc [4];
  chacha_state_pkg::word_t  qd [4];
  chacha_state_pkg::word_t  pa [4];
  chacha_state_pkg::word_t  pb [4];
  chacha_state_pkg::word_t  pc [4];
  chacha_state_pkg::word_t  pd [4];

  // --------------------------------------------------
  // Routing
  // --------------------------------------------------
  // Columns keep row offset 0, diagonals shift row r by r positions
  always_comb
  begin
    int shift;
    shift = int'(diag_sel);
    round_next = state_r;
    for (int i = 0; i < 4; i++)
    begin
      qa[i] = state_r[i];
      qb[i] = state_r[4 + ((i + shift) % 4)];
      qc[i] = state_r[8 + ((i + 2 * shift) % 4)];
      qd[i] = state_r[12 + ((i + 3 * shift) % 4)];
      // Results go back to the positions they came from
      round_next[i] = pa[i];
      round_next[4 + ((i + shift) % 4)] = pb[i];
      round_next[8 + ((i + 2 * shift) % 4)] = pc[i];
      round_next[12 + ((i + 3 * shift) % 4)] = pd[i];
    end
  end

  for (genvar g = 0; g < 4; g++)
  begin : g_qr
    chacha_qr u_qr (
      .a      (qa[g]),
      .b      (qb[g]),
      .c      (qc[g]),
      .d      (qd[g]),
      .a_prim (pa[g]),
      .b_prim (pb[g]),
      .c_prim (pc[g]),
      .d_prim (pd[g])
    );
  end

  // --------------------------------------------------
  // State register
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (dr_ctr_rst)
    begin
      for (int i = 0; i < `CHACHA_NUM_WORDS; i++)
      begin
        state_r[i] <= '0;
      end
    end
    else if (load_state)
    begin
      state_r <= init_words;
    end
    else if (update_state)
    begin
      state_r <= round_next;
    end
  end

  assign state_words = state_r;

  // Controller never loads and steps in the same cycle
  a_load_xor_update: assert property (@(posedge clk) disable iff (dr_ctr_rst)
    !(load_state && update_state));

endmodule

//--- chacha_state_pkg.sv
/*
 * State word types and constants for the ChaCha block function
 * Only the 256-bit key constants ("expand 32-byte k") are provided
 */
`include "chacha_defines.svh"

package chacha_state_pkg;

  typedef logic [`CHACHA_WORD_W-1:0] word_t;
  typedef word_t state_t [`CHACHA_NUM_WORDS];

  // Constant words 0 to 3 of the initial state
  localparam word_t SIGMA0 = 32'h61707865;
  localparam word_t SIGMA1 = 32'h3320646e;
  localparam word_t SIGMA2 = 32'h79622d32;
  localparam word_t SIGMA3 = 32'h6b206574;

  // Reverse byte order, big endian port words to little endian state words
  function automatic word_t byte_swap(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

endpackage

//--- filelist.f
+incdir+.
chacha_state_pkg.sv
chacha_ctrl_pkg.sv
chacha_qr.sv
chacha_init_state.sv
chacha_round.sv
chacha_block_ctr.sv
chacha_finalize.sv
chacha_ctrl.sv
chacha_core.sv
tb_chacha_core.sv

//--- tb_chacha_core.sv
/*
 * Table-driven testbench for the ChaCha core
 * Expected blocks come from a behavioral model run before reset release
 * Pulses for the busy-time entries need rounds of at least 4
 */
`timescale 1ns/1ps
`include "chacha_defines.svh"

module tb_chacha_core;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int NUM_TESTS  = 8;
  localparam int MAX_WAIT   = 40;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (20 + 4) + RST_CYCLES + 100;
  // First ChaCha20 keystream block for zero key, nonce and counter
  localparam logic [511:0] PUBLISHED = {128'h76b8e0ada0f13d90405d6ae55386bd28,
                                        128'hbdd219b8a08ded1aa836efcc8b770dc7,
                                        128'hda41597c5157488d7724e03fb8d84a37,
                                        128'h6a43b8f41518a11cc387b669b2ee6586};

  logic                        clk;
  logic                        dr_ctr_rst;
  logic                        init;
  logic                        next;
  logic [`CHACHA_KEY_W-1:0]    key;
  logic [`CHACHA_IV_W-1:0]     iv;
  logic [`CHACHA_CTR_W-1:0]    ctr;
  logic [`CHACHA_ROUNDS_W-1:0] rounds;
  logic [`CHACHA_BLOCK_W-1:0]  data_in;
  logic                        ready;
  logic [`CHACHA_BLOCK_W-1:0]  data_out;
  logic                        data_out_valid;

  // Stimulus and expected value table
  logic                        op_next     [NUM_TESTS];
  logic                        disturb_tab [NUM_TESTS];
  logic [`CHACHA_KEY_W-1:0]    key_tab     [NUM_TESTS];
  logic [`CHACHA_IV_W-1:0]     iv_tab      [NUM_TESTS];
  logic [`CHACHA_CTR_W-1:0]    ctr_tab     [NUM_TESTS];
  logic [`CHACHA_ROUNDS_W-1:0] rounds_tab  [NUM_TESTS];
  logic [`CHACHA_BLOCK_W-1:0]  data_tab    [NUM_TESTS];
  logic [`CHACHA_BLOCK_W-1:0]  exp_tab     [NUM_TESTS];

  integer                      seed = 32'hb13c_bfd4;
  int                          n_entries = 0;
  int                          errors = 0;
  int                          tests_ok = 0;
  int                          tests_bad = 0;
  logic [`CHACHA_CTR_W-1:0]    model_ctr = '0;

  chacha_core DUT (
    .clk            (clk),
    .dr_ctr_rst     (dr_ctr_rst),
    .init           (init),
    .next           (next),
    .key            (key),
    .iv             (iv),
    .ctr            (ctr),
    .rounds         (rounds),
    .data_in        (data_in),
    .ready          (ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // --------------------------------------------------
  // Behavioral model
  // --------------------------------------------------
  function automatic logic [31:0] rotate_left(input logic [31:0] v, input int s);
    logic [63:0] t;
    t = {v, v};
    return t[(63 - s) -: 32];
  endfunction

  // Bytes of a word in reverse order
  function automatic logic [31:0] le_word(input logic [31:0] w);
    logic [31:0] r;
    for (int b = 0; b < 4; b++)
    begin
      r[8*b +: 8] = w[31 - 8*b -: 8];
    end
    return r;
  endfunction

  function automatic logic [127:0] quarter(input logic [31:0] a, input logic [31:0] b,
                                           input logic [31:0] c, input logic [31:0] d);
    a = a + b;
    d = rotate_left(d ^ a, 16);
    c = c + d;
    b = rotate_left(b ^ c, 12);
    a = a + b;
    d = rotate_left(d ^ a, 8);
    c = c + d;
    b = rotate_left(b ^ c, 7);
    return {a, b, c, d};
  endfunction

  function automatic logic [511:0] chacha_block(input logic [255:0] k, input logic [63:0] n,
                                                input logic [63:0] c, input logic [4:0] r,
                                                input logic [511:0] d);
    logic [31:0]  s [16];
    logic [31:0]  x [16];
    logic [511:0] ks;
    // "expand 32-byte k"
    s[0] = 32'h61707865;
    s[1] = 32'h3320646e;
    s[2] = 32'h79622d32;
    s[3] = 32'h6b206574;
    for (int i = 0; i < 8; i++)
    begin
      s[4 + i] = le_word(k[255 - 32*i -: 32]);
    end
    s[12] = c[31:0];
    s[13] = c[63:32];
    s[14] = le_word(n[63:32]);
    s[15] = le_word(n[31:0]);
    for (int i = 0; i < 16; i++)
    begin
      x[i] = s[i];
    end
    for (int i = 0; i < r / 2; i++)
    begin
      // Column round
      {x[0], x[4], x[8], x[12]}  = quarter(x[0], x[4], x[8], x[12]);
      {x[1], x[5], x[9], x[13]}  = quarter(x[1], x[5], x[9], x[13]);
      {x[2], x[6], x[10], x[14]} = quarter(x[2], x[6], x[10], x[14]);
      {x[3], x[7], x[11], x[15]} = quarter(x[3], x[7], x[11], x[15]);
      // Diagonal round
      {x[0], x[5], x[10], x[15]} = quarter(x[0], x[5], x[10], x[15]);
      {x[1], x[6], x[11], x[12]} = quarter(x[1], x[6], x[11], x[12]);
      {x[2], x[7], x[8], x[13]}  = quarter(x[2], x[7], x[8], x[13]);
      {x[3], x[4], x[9], x[14]}  = quarter(x[3], x[4], x[9], x[14]);
    end
    for (int i = 0; i < 16; i++)
    begin
      ks[511 - 32*i -: 32] = le_word(x[i] + s[i]);
    end
    return ks ^ d;
  endfunction

  // --------------------------------------------------
  // Table setup
  // --------------------------------------------------
  task automatic random_block(output logic [511:0] v);
    for (int i = 0; i < 16; i++)
    begin
      v = {v[479:0], $random(seed)};
    end
  endtask

  // Next entries reuse the previous key and nonce, counter tracked in model_ctr
  task automatic add_entry(input logic is_next, input int r, input logic disturb,
                           input logic all_zero, input logic low_ones);
    logic [511:0] rnd;
    random_block(rnd);
    key_tab[n_entries] = rnd[255:0];
    iv_tab[n_entries]  = rnd[319:256];
    ctr_tab[n_entries] = rnd[383:320];
    random_block(rnd);
    data_tab[n_entries] = rnd;
    if (low_ones)
    begin
      ctr_tab[n_entries][31:0] = '1;
    end
    if (all_zero)
    begin
      key_tab[n_entries]  = '0;
      iv_tab[n_entries]   = '0;
      ctr_tab[n_entries]  = '0;
      data_tab[n_entries] = '0;
    end
    if (is_next)
    begin
      key_tab[n_entries] = key_tab[n_entries - 1];
      iv_tab[n_entries]  = iv_tab[n_entries - 1];
      model_ctr = model_ctr + 1'b1;
    end
    else
    begin
      model_ctr = ctr_tab[n_entries];
    end
    op_next[n_entries]     = is_next;
    rounds_tab[n_entries]  = r;
    disturb_tab[n_entries] = disturb;
    exp_tab[n_entries] = chacha_block(key_tab[n_entries], iv_tab[n_entries], model_ctr,
                                      rounds_tab[n_entries], data_tab[n_entries]);
    n_entries++;
  endtask

  // --------------------------------------------------
  // Checks and test sequence
  // --------------------------------------------------
  task automatic check_value(input string name, input logic [511:0] got,
                             input logic [511:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic run_entry(input int idx);
    int           n;
    int           errs_before;
    logic         done;
    logic [511:0] held;
    errs_before = errors;
    @(posedge clk);
    #2;
    key     = key_tab[idx];
    iv      = iv_tab[idx];
    ctr     = ctr_tab[idx];
    rounds  = rounds_tab[idx];
    data_in = data_tab[idx];
    init    = !op_next[idx];
    next    = op_next[idx];
    // Sampling edge
    @(posedge clk);
    #2;
    init = 1'b0;
    next = 1'b0;
    n    = 0;
    done = 1'b0;
    while (!done && n < MAX_WAIT)
    begin
      @(posedge clk);
      n++;
      #1;
      if (data_out_valid)
      begin
        done = 1'b1;
      end
      else
      begin
        check_value("ready", ready, 1'b0);
        // Pulses while busy, with a different counter on the port
        if (disturb_tab[idx] && n == 3)
        begin
          #1;
          init = 1'b1;
          ctr  = ~ctr_tab[idx];
        end
        else if (disturb_tab[idx] && n == 4)
        begin
          #1;
          init = 1'b0;
          next = 1'b1;
        end
        else if (disturb_tab[idx] && n == 5)
        begin
          #1;
          next = 1'b0;
        end
      end
    end
    if (!done)
    begin
      $display("Test %0d never raised data_out_valid within %0d cycles", idx, MAX_WAIT);
      errors++;
    end
    else
    begin
      check_value("data_out_valid latency", n, rounds_tab[idx] + 2);
      check_value("ready", ready, 1'b1);
      check_value("data_out", data_out, exp_tab[idx]);
      if (idx == 0)
      begin
        check_value("data_out vs published block", data_out, PUBLISHED);
      end
      held = data_out;
      // Result held while no pulse arrives
      repeat (2)
      begin
        @(posedge clk);
        #1;
        check_value("data_out_valid", data_out_valid, 1'b1);
        check_value("ready", ready, 1'b1);
        check_value("data_out", data_out, held);
      end
    end
    if (errors == errs_before)
    begin
      tests_ok++;
    end
    else
    begin
      tests_bad++;
    end
    $display("Test %0d %s rounds=%0d disturb=%0d: %s", idx, op_next[idx] ? "next" : "init",
             rounds_tab[idx], disturb_tab[idx], (errors == errs_before) ? "ok" : "mismatch");
  endtask

  // Watchdog sized from the table length
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, simulation did not finish", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    dr_ctr_rst = 1'b1;
    init       = 1'b0;
    next       = 1'b0;
    key        = '0;
    iv         = '0;
    ctr        = '0;
    rounds     = 5'd20;
    data_in    = '0;
    // Zero block, then a counter carry pair, then busy-time pulses
    add_entry(1'b0, 20, 1'b0, 1'b1, 1'b0);
    add_entry(1'b0, 8, 1'b0, 1'b0, 1'b1);
    add_entry(1'b1, 8, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 12, 1'b0, 1'b0, 1'b0);
    add_entry(1'b1, 12, 1'b1, 1'b0, 1'b0);
    add_entry(1'b0, 20, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 20, 1'b1, 1'b0, 1'b0);
    add_entry(1'b1, 20, 1'b0, 1'b0, 1'b0);
    check_value("model block 0 vs published block", exp_tab[0], PUBLISHED);
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    dr_ctr_rst = 1'b0;
    @(posedge clk);
    #1;
    check_value("ready", ready, 1'b1);
    check_value("data_out_valid", data_out_valid, 1'b0);
    check_value("data_out", data_out, '0);
    $display("Reset state check: %s", (errors == 0) ? "ok" : "mismatch");
    for (int i = 0; i < n_entries; i++)
    begin
      run_entry(i);
    end
    $display("Tests run %0d, ok %0d, mismatched %0d, check errors %0d",
             n_entries, tests_ok, tests_bad, errors);
    if (errors == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
